//--- files.f
src/cen_pkg.sv
src/cen_if.sv
src/frac_cen.sv
src/video_cen.sv
src/sound_cen.sv
src/cen_top.sv
test/tb_cen_top.sv

//--- test/tb_cen_top.sv
module tb_cen_top
    import cen_pkg::*;
();

    logic clk;
    logic clk_snd;
    logic rst_n;
    logic pxl2_cen, pxl_cen, cpu_cen, cpu_cenb;
    logic mcu_cen, snd_cen, fm_cen, fm2_cen, pcm_cen, pcm_cenb;
    logic checks_on;  // Set once the first reset has settled

    // Main model state, clk domain
    int   acc_pxl, acc_cpu;
    logic tog_pxl;
    logic e_pxl2, e_pxl, e_cpu, e_cpub;
    logic m_quiet, m_rst_d;  // Quiet window, seen reset one edge back

    // Sound model state, clk_snd domain
    int         acc_mcu, acc_fm, acc_snd, acc_pcm;
    logic       tog_fm;
    logic [1:0] s_sync;  // Two-edge release delay
    logic       e_mcu, e_snd, e_fm, e_fm2, e_pcm, e_pcmb;
    logic       s_quiet, s_rst_d;

    int main_cnt[4];  // DUT pulses, pxl2 pxl cpu cpub
    int main_ref[4];  // Model pulses, same order
    int snd_cnt[6];   // DUT pulses, mcu snd fm fm2 pcm pcmb
    int snd_ref[6];
    string names[10] = '{"pxl2_cen", "pxl_cen", "cpu_cen", "cpu_cenb", "mcu_cen",
                         "snd_cen", "fm_cen", "fm2_cen", "pcm_cen", "pcm_cenb"};

    cen_top cen_top_i (
        .clk      (clk),
        .clk_snd  (clk_snd),
        .rst_n    (rst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .mcu_cen  (mcu_cen),
        .snd_cen  (snd_cen),
        .fm_cen   (fm_cen),
        .fm2_cen  (fm2_cen),
        .pcm_cen  (pcm_cen),
        .pcm_cenb (pcm_cenb)
    );

    always #5 clk = ~clk;
    always #10 clk_snd = ~clk_snd;  // Half the clk rate, rising between clk rising edges

    // One divider step: {base, cenb, next accumulator}
    function automatic logic [15:0] div_step(input int acc, input int n, input int m);
        int   s;
        logic base;
        logic cb;
        int   nxt;
        s    = acc + n;
        base = (s >= m);
        cb   = 1'b0;
        if (base) begin
            nxt = s - m;
        end else begin
            nxt = s;
            cb  = (acc < m / 2) && (s >= m / 2);  // Crossing of the window middle
        end
        return {base, cb, nxt[13:0]};
    endfunction

    function automatic int pulse_count(input int i);
        if (i < 4) return main_cnt[i];
        else return snd_cnt[i - 4];
    endfunction

    function automatic int model_count(input int i);
        if (i < 4) return main_ref[i];
        else return snd_ref[i - 4];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Model of the main domain, reset seen at the same edge as the DUT
    always @(posedge clk) begin : main_model
        logic [15:0] r_pxl;
        logic [15:0] r_cpu;
        if (!rst_n) begin
            acc_pxl <= 0;
            acc_cpu <= 0;
            tog_pxl <= 1'b0;
            {e_pxl2, e_pxl, e_cpu, e_cpub} <= 4'b0;
        end else begin
            r_pxl = div_step(acc_pxl, PXL_N, PXL_M);
            r_cpu = div_step(acc_cpu, CPU_N, CPU_M);
            e_pxl2  <= r_pxl[15];
            e_pxl   <= r_pxl[15] & tog_pxl;  // Second, fourth, ... pxl2 event
            tog_pxl <= tog_pxl ^ r_pxl[15];
            acc_pxl <= r_pxl[13:0];
            e_cpu   <= r_cpu[15];
            e_cpub  <= r_cpu[14];
            acc_cpu <= r_cpu[13:0];
        end
        m_quiet <= !rst_n || !m_rst_d;  // Reset and first cycle after it
        m_rst_d <= rst_n;
    end

    // Model of the sound domain behind its two-edge reset delay
    always @(posedge clk_snd) begin : snd_model
        logic [15:0] r_mcu;
        logic [15:0] r_fm;
        logic [15:0] r_snd;
        logic [15:0] r_pcm;
        s_sync <= {s_sync[0], rst_n};
        if (!s_sync[1]) begin
            {acc_mcu, acc_fm, acc_snd, acc_pcm} <= '0;
            tog_fm <= 1'b0;  // Half-rate phase restarts
            {e_mcu, e_snd, e_fm, e_fm2, e_pcm, e_pcmb} <= 6'b0;
        end else begin
            r_mcu = div_step(acc_mcu, MCU_N, MCU_M);
            r_fm  = div_step(acc_fm, FM_N, FM_M);
            r_snd = div_step(acc_snd, SND_N, SND_M);
            r_pcm = div_step(acc_pcm, PCM_N, PCM_M);
            e_mcu   <= r_mcu[15];
            acc_mcu <= r_mcu[13:0];
            e_fm    <= r_fm[15];
            e_fm2   <= r_fm[15] & tog_fm;
            tog_fm  <= tog_fm ^ r_fm[15];
            acc_fm  <= r_fm[13:0];
            e_snd   <= r_snd[15];
            acc_snd <= r_snd[13:0];
            e_pcm   <= r_pcm[15];
            e_pcmb  <= r_pcm[14];
            acc_pcm <= r_pcm[13:0];
        end
        s_quiet <= !s_sync[1] || !s_rst_d;
        s_rst_d <= s_sync[1];
    end

    // Main compare, on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (checks_on) begin
            check_val("pxl2_cen", e_pxl2, pxl2_cen);
            check_val("pxl_cen", e_pxl, pxl_cen);
            check_val("cpu_cen", e_cpu, cpu_cen);
            check_val("cpu_cenb", e_cpub, cpu_cenb);
            check_val("cpu_cen & cpu_cenb", 1'b0, cpu_cen & cpu_cenb);
            if (m_quiet) check_val("main enables in reset", 4'b0,
                                   {pxl2_cen, pxl_cen, cpu_cen, cpu_cenb});
            main_cnt[0] += pxl2_cen;
            main_cnt[1] += pxl_cen;
            main_cnt[2] += cpu_cen;
            main_cnt[3] += cpu_cenb;
            main_ref[0] += e_pxl2;
            main_ref[1] += e_pxl;
            main_ref[2] += e_cpu;
            main_ref[3] += e_cpub;
        end
    end

    // Sound compare
    always @(negedge clk_snd) begin
        if (checks_on) begin
            check_val("mcu_cen", e_mcu, mcu_cen);
            check_val("snd_cen", e_snd, snd_cen);
            check_val("fm_cen", e_fm, fm_cen);
            check_val("fm2_cen", e_fm2, fm2_cen);
            check_val("pcm_cen", e_pcm, pcm_cen);
            check_val("pcm_cenb", e_pcmb, pcm_cenb);
            check_val("pcm_cen & pcm_cenb", 1'b0, pcm_cen & pcm_cenb);
            if (s_quiet) check_val("sound enables in reset", 6'b0,
                                   {mcu_cen, snd_cen, fm_cen, fm2_cen, pcm_cen, pcm_cenb});
            snd_cnt[0] += mcu_cen;
            snd_cnt[1] += snd_cen;
            snd_cnt[2] += fm_cen;
            snd_cnt[3] += fm2_cen;
            snd_cnt[4] += pcm_cen;
            snd_cnt[5] += pcm_cenb;
            snd_ref[0] += e_mcu;
            snd_ref[1] += e_snd;
            snd_ref[2] += e_fm;
            snd_ref[3] += e_fm2;
            snd_ref[4] += e_pcm;
            snd_ref[5] += e_pcmb;
        end
    end

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Every enable must fire at least once after a reset
    task automatic wait_all_pulsed();
        int start[10];
        int cycles;
        bit done;
        for (int i = 0; i < 10; i++) start[i] = pulse_count(i);
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 20000) begin
            @(posedge clk);
            cycles++;
            done = 1'b1;
            for (int i = 0; i < 10; i++) if (pulse_count(i) == start[i]) done = 1'b0;
        end
        if (!done) begin
            for (int i = 0; i < 10; i++) begin
                if (pulse_count(i) == start[i])
                    $display("Timeout: %s never pulsed within 20000 clk cycles", names[i]);
            end
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        int seg_len;
        int c_start[10];
        int r_start[10];
        void'($urandom(6));
        clk       = 1'b0;
        clk_snd   = 1'b0;
        rst_n     = 1'b0;
        checks_on = 1'b0;
        s_sync    = 2'b00;
        repeat (6) @(posedge clk);  // Sound side cleared by now
        checks_on = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int seg = 0; seg < 3; seg++) begin
            if (seg > 0) apply_reset();  // Mid-run reset between segments
            for (int i = 0; i < 10; i++) begin
                c_start[i] = pulse_count(i);
                r_start[i] = model_count(i);
            end
            wait_all_pulsed();
            seg_len = 1 + ($urandom % 2000);
            repeat (seg_len) @(posedge clk);
            for (int i = 0; i < 10; i++)
                check_val({names[i], " pulse count"}, model_count(i) - r_start[i],
                          pulse_count(i) - c_start[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- src/cen_top.sv
module cen_top (
    input  logic clk,       // Main and video clock
    input  logic clk_snd,   // Sound subsystem clock
    input  logic rst_n,

    // Main domain
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic cpu_cen,
    output logic cpu_cenb,

    // Sound domain
    output logic mcu_cen,
    output logic snd_cen,
    output logic fm_cen,
    output logic fm2_cen,
    output logic pcm_cen,
    output logic pcm_cenb
);

    vid_cen_if vid_if ();  // Video and CPU bundle
    snd_cen_if snd_if ();  // Sound bundle

    video_cen u_video (
        .clk   (clk),
        .rst_n (rst_n),
        .vid   (vid_if.gen)
    );

    sound_cen u_sound (
        .clk_snd (clk_snd),
        .rst_n   (rst_n),
        .snd     (snd_if.gen)
    );

    // Read side of the video bundle
    assign pxl2_cen = vid_if.pxl2_cen;
    assign pxl_cen  = vid_if.pxl_cen;
    assign cpu_cen  = vid_if.cpu_cen;
    assign cpu_cenb = vid_if.cpu_cenb;

    // Read side of the sound bundle
    assign mcu_cen  = snd_if.mcu_cen;
    assign snd_cen  = snd_if.snd_cen;
    assign fm_cen   = snd_if.fm_cen;
    assign fm2_cen  = snd_if.fm2_cen;
    assign pcm_cen  = snd_if.pcm_cen;
    assign pcm_cenb = snd_if.pcm_cenb;

endmodule

//--- src/sound_cen.sv
module sound_cen
    import cen_pkg::*;
(
    input  logic   clk_snd,
    input  logic   rst_n,   // From the main domain
    snd_cen_if.gen snd
);

    logic [1:0] rst_sync;   // Two-flop reset shifter
    logic       rst_snd_n;  // Local reset, clk_snd aligned

    // rst_n is not timed to clk_snd, so it goes through two flops
    always_ff @(posedge clk_snd) begin
        rst_sync <= {rst_sync[0], rst_n};
    end

    assign rst_snd_n = rst_sync[1];

    // Sound MCU
    frac_cen #(
        .WC (WC_NARROW),
        .N  (MCU_N),
        .M  (MCU_M)
    ) u_mcu (
        .clk      (clk_snd),
        .rst_n    (rst_snd_n),
        .cen      (snd.mcu_cen),
        .cen_half (),
        .cenb     ()
    );

    // FM chip, plus its half-rate enable
    frac_cen #(
        .WC (WC_NARROW),
        .N  (FM_N),
        .M  (FM_M)
    ) u_fm (
        .clk      (clk_snd),
        .rst_n    (rst_snd_n),
        .cen      (snd.fm_cen),
        .cen_half (snd.fm2_cen),
        .cenb     ()
    );

    // Sound CPU
    frac_cen #(
        .WC (WC_WIDE),
        .N  (SND_N),
        .M  (SND_M)
    ) u_snd (
        .clk      (clk_snd),
        .rst_n    (rst_snd_n),
        .cen      (snd.snd_cen),
        .cen_half (),
        .cenb     ()
    );

    // PCM with opposite phase
    frac_cen #(
        .WC (WC_WIDE),
        .N  (PCM_N),
        .M  (PCM_M)
    ) u_pcm (
        .clk      (clk_snd),
        .rst_n    (rst_snd_n),
        .cen      (snd.pcm_cen),
        .cen_half (),
        .cenb     (snd.pcm_cenb)
    );

    // Local reset trails the board reset by two clk_snd edges
    a_rst_delay: assert property (
        @(posedge clk_snd)
        $rose(rst_snd_n) |-> $past(rst_n, 1) && $past(rst_n, 2)
    );

endmodule

//--- src/video_cen.sv
module video_cen
    import cen_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    vid_cen_if.gen vid
);

    // Pixel pair, 2x and 1x from one divider
    frac_cen #(
        .WC (WC_NARROW),
        .N  (PXL_N),
        .M  (PXL_M)
    ) u_pxl (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (vid.pxl2_cen),
        .cen_half (vid.pxl_cen),  // Every second pxl2 pulse
        .cenb     ()
    );

    // CPU enable with its opposite phase
    frac_cen #(
        .WC (WC_NARROW),
        .N  (CPU_N),
        .M  (CPU_M)
    ) u_cpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (vid.cpu_cen),
        .cen_half (),
        .cenb     (vid.cpu_cenb)  // Mid-cycle phase for the bus
    );

endmodule

//--- src/frac_cen.sv
module frac_cen #(
    parameter int WC = 10,  // Accumulator width
    parameter int N  = 1,   // Pulses per window
    parameter int M  = 2    // Window length in clocks
) (
    input  logic clk,
    input  logic rst_n,
    output logic cen,       // Base enable
    output logic cen_half,  // Every second base enable
    output logic cenb       // Mid-window phase
);

    localparam logic [WC-1:0] N_W    = WC'(N);
    localparam logic [WC-1:0] M_W    = WC'(M);
    localparam logic [WC-1:0] HALF_W = M_W >> 1;  // Mid point of the window

    logic [WC-1:0] acc;   // Phase accumulator, always below M
    logic [WC:0]   sum;   // Spare top bit for acc + N
    logic [WC:0]   wrap;  // Sum folded back by M
    logic          over;  // Base event this cycle
    logic          mid;   // Crossing of M/2
    logic          tog;   // Base event parity

    assign sum  = {1'b0, acc} + {1'b0, N_W};
    assign wrap = sum - {1'b0, M_W};
    assign over = sum >= {1'b0, M_W};
    assign mid  = (acc < HALF_W) && (sum >= {1'b0, HALF_W});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc      <= '0;
            tog      <= 1'b0;
            cen      <= 1'b0;
            cen_half <= 1'b0;
            cenb     <= 1'b0;
        end else begin
            cen      <= over;         // Registered, one cycle late
            cen_half <= over & tog;   // Second, fourth, ... base event
            cenb     <= ~over & mid;  // Only on cycles without a base event
            if (over) begin
                acc <= wrap[WC-1:0];  // Fits, wrap is below N
                tog <= ~tog;
            end else begin
                acc <= sum[WC-1:0];   // Below M here
            end
        end
    end

    // Mid-window crossing cannot repeat on the next clock
    a_cenb_spaced: assert property (
        @(posedge clk) disable iff (!rst_n)
        cenb |=> !cenb
    );

    // Accumulator never reaches the window length
    a_acc_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc < M_W
    );

endmodule

//--- src/cen_if.sv
interface vid_cen_if;

    logic pxl2_cen;  // Pixel enable at 2x
    logic pxl_cen;   // Pixel enable
    logic cpu_cen;   // CPU enable
    logic cpu_cenb;  // CPU enable, opposite phase

    modport gen (
        output pxl2_cen, pxl_cen, cpu_cen, cpu_cenb
    );

    modport sink (
        input pxl2_cen, pxl_cen, cpu_cen, cpu_cenb
    );

endinterface

interface snd_cen_if;

    logic mcu_cen;   // Sound MCU
    logic snd_cen;   // Sound CPU
    logic fm_cen;    // FM chip
    logic fm2_cen;   // FM at half rate
    logic pcm_cen;   // PCM chip
    logic pcm_cenb;  // PCM, opposite phase

    modport gen (
        output mcu_cen, snd_cen, fm_cen, fm2_cen, pcm_cen, pcm_cenb
    );

    modport sink (
        input mcu_cen, snd_cen, fm_cen, fm2_cen, pcm_cen, pcm_cenb
    );

endinterface

//--- src/cen_pkg.sv
package cen_pkg;

    // Accumulator widths
    localparam int WC_NARROW = 10;  // Enough for ratios with M below 1024
    localparam int WC_WIDE   = 14;  // Large-denominator dividers

    // Main domain, clk
    localparam int PXL_N = 1;    // Pixel 2x enable
    localparam int PXL_M = 4;    // Quarter of clk
    localparam int CPU_N = 29;   // CPU enable
    localparam int CPU_M = 146;  // Roughly a fifth of clk

    // Sound domain, clk_snd
    localparam int MCU_N = 143;   // Sound MCU enable
    localparam int MCU_M = 450;
    localparam int FM_N  = 143;   // FM enable, half of the MCU rate
    localparam int FM_M  = 900;
    localparam int SND_N = 1373;  // Sound CPU enable
    localparam int SND_M = 6913;
    localparam int PCM_N = 1619;  // PCM enable
    localparam int PCM_M = 6793;

    // FM_M sits under 1024, but acc plus N can pass it, so the
    // divider keeps one spare bit on its sum

endpackage
